/* build.f */
src/exec_pkg.sv
src/detachable_alu.sv
src/iter_muldiv.sv
src/step_counter.sv
src/exec_ctrl.sv
src/exec_unit.sv
tb/exec_unit_props.sv
tb/exec_unit_tb.sv

/* tb/exec_unit_tb.sv */
module exec_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import exec_pkg::*;

    localparam int          CLK_PERIOD = 20;
    localparam int          MAX_OPS    = 2000;
    localparam int          OP_CYCLES  = 40;
    localparam int          WAIT_LIMIT = 100;  // cycles allowed for one done
    localparam logic [31:0] SEED       = 32'hfa36;
    localparam logic [31:0] MSB        = 32'h8000_0000;

    logic            clk;
    logic            reset_i;
    logic            start_i;
    exec_req_t       req_i;
    logic [XLEN-1:0] result_o;
    logic            done_o;
    logic            busy_o;
    int              n_ops = 0;

    exec_unit DUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .req_i    (req_i),
        .result_o (result_o),
        .done_o   (done_o),
        .busy_o   (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // every operation counted at more than the length of a divide
    initial begin
        #(MAX_OPS * OP_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog timeout");
    end

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "check of %s failed", name);
        end
    endtask

    function automatic logic [XLEN-1:0] pick_operand();
        case ($urandom_range(0, 11))
            0:       return 32'h0;
            1:       return 32'h1;
            2:       return 32'hffff_ffff;
            3:       return MSB;
            4:       return 32'h7fff_ffff;
            5:       return 32'd31;
            default: return $urandom();
        endcase
    endfunction

    function automatic exec_req_t make_req(input int g, input int op,
                                           input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
        exec_req_t r;
        r.group = alu_group_e'(g);
        r.op    = alu_op_e'(op);
        r.r1    = a;
        r.r0    = b;
        r.pc    = $urandom();
        return r;
    endfunction

    function automatic exec_req_t rand_req();
        return make_req($urandom_range(0, 5), $urandom_range(0, 3),
                        pick_operand(), pick_operand());
    endfunction

    // expected result with r1 on the left and r0 on the right
    function automatic logic [XLEN-1:0] model(input exec_req_t r);
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [2*XLEN-1:0] prod;
        logic [2*XLEN-1:0] ext;
        a    = r.r1;
        b    = r.r0;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        ext  = {{XLEN{a[XLEN-1]}}, a} >> b[4:0];   // sign-filled
        case ({r.group, r.op})
            {GRP_BW,  OP_NOR}:   return ~(a | b);
            {GRP_BW,  OP_AND}:   return a & b;
            {GRP_BW,  OP_OR}:    return a | b;
            {GRP_BW,  OP_XOR}:   return a ^ b;
            {GRP_INT, OP_ADD}:   return a + b;
            {GRP_INT, OP_SUB}:   return a + ~b + 1;
            {GRP_SFT, OP_SLL}:   return a << b[4:0];
            {GRP_SFT, OP_SRL}:   return a >> b[4:0];
            {GRP_SFT, OP_SRA}:   return ext[XLEN-1:0];
            {GRP_CMP, OP_SLT}:   return {31'd0, (a ^ MSB) < (b ^ MSB)};
            {GRP_CMP, OP_SLTU}:  return {31'd0, a < b};
            {GRP_MD,  OP_MUL}:   return prod[XLEN-1:0];
            {GRP_MD,  OP_MULHU}: return prod[2*XLEN-1:XLEN];
            {GRP_MD,  OP_DIVU}:  return (b == 0) ? {XLEN{1'b1}} : a / b;
            {GRP_MD,  OP_MODU}:  return (b == 0) ? a : a % b;
            default:             return '0;   // LI detached and unused sub-ops
        endcase
    endfunction

    // number of edges after the accepted start that see a dropped start
    task automatic run_op(input exec_req_t r, input int noise);
        logic [XLEN-1:0] exp;
        int              exp_lat;
        int              lat;
        exp     = model(r);
        exp_lat = (r.group == GRP_MD) ? 34 : 2;
        @(posedge clk);
        start_i <= 1'b1;
        req_i   <= r;
        @(posedge clk);     // this edge takes the start
        lat = 0;
        forever begin
            if (lat < noise) begin
                start_i <= 1'b1;
                req_i   <= rand_req();
            end else begin
                start_i <= 1'b0;
            end
            @(negedge clk);
            lat++;
            if (done_o || lat >= WAIT_LIMIT) break;
            check("busy_o", {31'd0, busy_o}, 32'd1);
            @(posedge clk);
        end
        if (!done_o) begin
            $display("no done_o within %0d cycles of the start", WAIT_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "done timeout");
        end else begin
            check("latency", lat, exp_lat);
            check("busy_o", {31'd0, busy_o}, 32'd0);
            check("result_o", result_o, exp);
            n_ops++;
        end
    endtask

    initial begin
        int reps;
        void'($urandom(SEED));
        reset_i <= 1'b1;
        start_i <= 1'b0;
        req_i   <= '0;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;

        // idle after reset
        repeat (5) begin
            @(negedge clk);
            check("done_o", {31'd0, done_o}, 32'd0);
            check("busy_o", {31'd0, busy_o}, 32'd0);
            check("result_o", result_o, 32'd0);
        end

        for (int g = 0; g < 6; g++) begin
            reps = (g == GRP_LI) ? 8 : (g == GRP_MD) ? 25 : 30;
            for (int op = 0; op < 4; op++) begin
                repeat (reps) run_op(make_req(g, op, pick_operand(), pick_operand()), 0);
            end
        end

        for (int op = 0; op < 3; op++) begin
            run_op(make_req(GRP_SFT, op, 32'h8000_0001, 32'd31), 0);
            run_op(make_req(GRP_SFT, op, 32'hf0f0_1234, 32'hffff_ffff), 0);
        end
        for (int op = 0; op < 2; op++) begin
            run_op(make_req(GRP_CMP, op, MSB, 32'h7fff_ffff), 0);
            run_op(make_req(GRP_CMP, op, 32'h7fff_ffff, MSB), 0);
            run_op(make_req(GRP_CMP, op, 32'hffff_ffff, 32'h0), 0);
        end
        for (int op = 0; op < 4; op++) begin
            run_op(make_req(GRP_MD, op, $urandom(), 32'd0), 0);
            run_op(make_req(GRP_MD, op, $urandom(), 32'd1), 0);
        end

        // starts while busy must be dropped
        repeat (80) begin
            exec_req_t r;
            r = rand_req();
            run_op(r, (r.group == GRP_MD) ? $urandom_range(1, 33) : 1);
        end

        $display("%0d operations checked", n_ops);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* tb/exec_unit_props.sv */
module exec_unit_props (
    input logic clk,
    input logic reset_i,
    input logic start_i,
    input logic done_o,
    input logic busy_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // done is a one-cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o)
        else $error("done_o stayed high for more than one cycle");

    // an accepted start makes the unit busy
    start_takes: assert property (@(posedge clk) disable iff (reset_i)
        (start_i && !busy_o) |=> busy_o)
        else $error("accepted start did not raise busy_o");

    quiet_after_reset: assert property (@(posedge clk) reset_i |=> (!busy_o && !done_o))
        else $error("busy_o or done_o high right after reset");

endmodule

bind exec_unit exec_unit_props u_props (
    .clk     (clk),
    .reset_i (reset_i),
    .start_i (start_i),
    .done_o  (done_o),
    .busy_o  (busy_o)
);

/* src/exec_unit.sv */
module exec_unit #(
    parameter bit USE_INT = 1,
    parameter bit USE_LI  = 0,
    parameter bit USE_SFT = 1,
    parameter bit USE_CMP = 1,
    parameter bit USE_MD  = 1
) (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       start_i,
    input  exec_pkg::exec_req_t        req_i,
    output logic [exec_pkg::XLEN-1:0]  result_o,
    output logic                       done_o,
    output logic                       busy_o
);
    import exec_pkg::*;

    exec_req_t       req_q;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] md_res;
    logic [XLEN-1:0] result_q;
    logic            load;
    logic            md_init;
    logic            md_step;
    logic            cnt_load;
    logic            sel_md;
    logic            res_we;
    logic            last;

    exec_ctrl #(.USE_MD(USE_MD)) u_ctrl (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .group_i    (req_i.group),
        .last_i     (last),
        .load_o     (load),
        .md_init_o  (md_init),
        .md_step_o  (md_step),
        .cnt_load_o (cnt_load),
        .sel_md_o   (sel_md),
        .res_we_o   (res_we),
        .done_o     (done_o),
        .busy_o     (busy_o)
    );

    step_counter #(.STEPS(XLEN)) u_cnt (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (cnt_load),
        .en_i    (md_step),
        .last_o  (last)
    );

    always_ff @(posedge clk) begin
        if (load) begin
            req_q <= req_i;
        end
    end

    detachable_alu #(
        .USE_INT (USE_INT),
        .USE_LI  (USE_LI),
        .USE_SFT (USE_SFT),
        .USE_CMP (USE_CMP)
    ) u_alu (
        .req_i (req_q),
        .res_o (alu_res)
    );

    if (USE_MD) begin : g_md
        iter_muldiv u_md (
            .clk     (clk),
            .reset_i (reset_i),
            .req_i   (req_q),
            .init_i  (md_init),
            .step_i  (md_step),
            .res_o   (md_res)
        );
    end else begin : g_no_md
        assign md_res = '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_q <= '0;
        end else if (res_we) begin
            result_q <= sel_md ? md_res : alu_res;
        end
    end

    assign result_o = result_q;     // held until the next write

endmodule

/* src/exec_ctrl.sv */
module exec_ctrl #(
    parameter bit USE_MD = 1
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  start_i,
    input  exec_pkg::alu_group_e  group_i,
    input  logic                  last_i,
    output logic                  load_o,
    output logic                  md_init_o,
    output logic                  md_step_o,
    output logic                  cnt_load_o,
    output logic                  sel_md_o,
    output logic                  res_we_o,
    output logic                  done_o,
    output logic                  busy_o
);
    import exec_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ALU,
        MD_INIT,
        MD_RUN,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    assign busy_o     = (state_q == ALU) || (state_q == MD_INIT) || (state_q == MD_RUN);
    assign done_o     = (state_q == DONE);
    assign load_o     = start_i && !busy_o;   // accepted in IDLE and DONE
    assign md_init_o  = (state_q == MD_INIT);
    assign cnt_load_o = (state_q == MD_INIT);
    assign md_step_o  = (state_q == MD_RUN);
    assign sel_md_o   = (state_q == MD_RUN);
    assign res_we_o   = (state_q == ALU) || (state_q == MD_RUN && last_i);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (load_o) begin
                    if (USE_MD && group_i == GRP_MD) begin
                        state_d = MD_INIT;
                    end else begin
                        state_d = ALU;
                    end
                end else begin
                    state_d = IDLE;
                end
            end
            ALU:     state_d = DONE;
            MD_INIT: state_d = MD_RUN;
            MD_RUN: begin
                if (last_i) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* src/step_counter.sv */
module step_counter #(
    parameter int STEPS = 32
) (
    input  logic clk,
    input  logic reset_i,
    input  logic load_i,
    input  logic en_i,
    output logic last_o
);
    localparam int CW = (STEPS > 1) ? $clog2(STEPS) : 1;

    logic [CW-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= CW'(STEPS - 1);
        end else if (en_i && cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign last_o = (cnt_q == '0);  // zero marks the final step

endmodule

/* src/iter_muldiv.sv */
module iter_muldiv (
    input  logic                       clk,
    input  logic                       reset_i,
    input  exec_pkg::exec_req_t        req_i,
    input  logic                       init_i,
    input  logic                       step_i,
    output logic [exec_pkg::XLEN-1:0]  res_o
);
    import exec_pkg::*;

    // hi/lo form the 64-bit accumulator, or remainder/quotient when dividing
    logic [XLEN-1:0] hi_q;
    logic [XLEN-1:0] lo_q;
    logic [XLEN-1:0] opnd_q;    // multiplicand or divisor
    logic            is_div;
    logic [XLEN:0]   sum;
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] hi_nx;
    logic [XLEN-1:0] lo_nx;
    logic [XLEN-1:0] hi_v;
    logic [XLEN-1:0] lo_v;

    assign is_div = (req_i.op == OP_DIVU) || (req_i.op == OP_MODU);

    always_comb begin
        sum     = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opnd_q} : {(XLEN+1){1'b0}});
        shifted = {hi_q, lo_q[XLEN-1]};
        diff    = shifted - {1'b0, opnd_q};
        if (is_div) begin
            if (!diff[XLEN]) begin
                hi_nx = diff[XLEN-1:0];     // subtract fits and sets the quotient bit
                lo_nx = {lo_q[XLEN-2:0], 1'b1};
            end else begin
                hi_nx = shifted[XLEN-1:0];  // restore
                lo_nx = {lo_q[XLEN-2:0], 1'b0};
            end
        end else begin
            hi_nx = sum[XLEN:1];
            lo_nx = {sum[0], lo_q[XLEN-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (init_i) begin
            hi_q <= '0;
            lo_q <= is_div ? req_i.r1 : req_i.r0;
        end else if (step_i) begin
            hi_q <= hi_nx;
            lo_q <= lo_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (init_i) begin
            opnd_q <= is_div ? req_i.r0 : req_i.r1;
        end
    end

    // during a step show the value after it, so the last step can be captured
    assign hi_v = step_i ? hi_nx : hi_q;
    assign lo_v = step_i ? lo_nx : lo_q;

    always_comb begin
        case (req_i.op)
            OP_MULHU, OP_MODU: res_o = hi_v;
            default:           res_o = lo_v;    // MUL low word, DIVU quotient
        endcase
    end

endmodule

/* src/detachable_alu.sv */
module detachable_alu #(
    parameter bit USE_INT = 1,
    parameter bit USE_LI  = 0,
    parameter bit USE_SFT = 1,
    parameter bit USE_CMP = 1
) (
    input  exec_pkg::exec_req_t        req_i,
    output logic [exec_pkg::XLEN-1:0]  res_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;

    assign a = req_i.r1;
    assign b = req_i.r0;

    always_comb begin
        res_o = '0;
        case (req_i.group)
            GRP_BW: begin
                case (req_i.op)
                    OP_NOR:  res_o = ~(a | b);
                    OP_AND:  res_o = a & b;
                    OP_OR:   res_o = a | b;
                    OP_XOR:  res_o = a ^ b;
                    default: res_o = '0;
                endcase
            end
            GRP_INT: begin
                if (USE_INT) begin
                    case (req_i.op)
                        OP_ADD:  res_o = a + b;
                        OP_SUB:  res_o = a - b;
                        default: res_o = '0;
                    endcase
                end
            end
            GRP_LI: begin
                // LI only exists when INT is detached
                if (!USE_INT && USE_LI) begin
                    case (req_i.op)
                        OP_LUI:     res_o = {b[19:0], 12'd0};
                        OP_PCPLUS4: res_o = a + b;
                        OP_PCADDUI: res_o = b + req_i.pc;
                        default:    res_o = '0;
                    endcase
                end
            end
            GRP_SFT: begin
                if (USE_SFT) begin
                    case (req_i.op)
                        OP_SLL:  res_o = a << b[4:0];
                        OP_SRL:  res_o = a >> b[4:0];
                        OP_SRA:  res_o = $unsigned($signed(a) >>> b[4:0]);
                        default: res_o = '0;
                    endcase
                end
            end
            GRP_CMP: begin
                if (USE_CMP) begin
                    case (req_i.op)
                        OP_SLT:  res_o = XLEN'($signed(a) < $signed(b));
                        OP_SLTU: res_o = XLEN'(a < b);
                        default: res_o = '0;
                    endcase
                end
            end
            default: res_o = '0;    // MD comes from the iterative unit
        endcase
    end

endmodule

/* src/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN = 32;

    typedef enum logic [2:0] {
        GRP_BW,
        GRP_INT,
        GRP_LI,
        GRP_SFT,
        GRP_CMP,
        GRP_MD
    } alu_group_e;

    // sub-op slots whose meaning depends on the group
    typedef enum logic [1:0] {
        OP_S0,
        OP_S1,
        OP_S2,
        OP_S3
    } alu_op_e;

    localparam alu_op_e OP_NOR     = OP_S0;
    localparam alu_op_e OP_AND     = OP_S1;
    localparam alu_op_e OP_OR      = OP_S2;
    localparam alu_op_e OP_XOR     = OP_S3;

    localparam alu_op_e OP_ADD     = OP_S0;
    localparam alu_op_e OP_SUB     = OP_S2;

    localparam alu_op_e OP_LUI     = OP_S1;
    localparam alu_op_e OP_PCPLUS4 = OP_S2;
    localparam alu_op_e OP_PCADDUI = OP_S3;

    localparam alu_op_e OP_SLL     = OP_S0;
    localparam alu_op_e OP_SRL     = OP_S1;
    localparam alu_op_e OP_SRA     = OP_S2;

    localparam alu_op_e OP_SLT     = OP_S0;
    localparam alu_op_e OP_SLTU    = OP_S1;

    localparam alu_op_e OP_MUL     = OP_S0;
    localparam alu_op_e OP_MULHU   = OP_S1;
    localparam alu_op_e OP_DIVU    = OP_S2;
    localparam alu_op_e OP_MODU    = OP_S3;

    typedef struct packed {
        alu_group_e      group;
        alu_op_e         op;
        logic [XLEN-1:0] r0;    // right operand
        logic [XLEN-1:0] r1;    // left operand
        logic [XLEN-1:0] pc;
    } exec_req_t;

endpackage
